// ==== bench/banked_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module banked_mem_tb;

    import mem_pkg::*;

    localparam int MAX_CYCLES = 4000;
    localparam int unsigned SEED = 32'h5b49_adf4;

    logic  clk;
    logic  reset;
    logic  cs;
    logic  we;
    addr_t addr;
    strb_t strb;
    data_t wdata;
    data_t rdata;

    // reference model keyed by {bank, word}
    data_t model [int];
    data_t last_rd;
    int    errors;
    int    checks;
    int    cycles = 0;

    clk_gen u_clk_gen (
        .clk ( clk )
    );

    banked_mem dut0 (
        .clk   ( clk   ),
        .reset ( reset ),
        .cs    ( cs    ),
        .we    ( we    ),
        .addr  ( addr  ),
        .strb  ( strb  ),
        .wdata ( wdata ),
        .rdata ( rdata )
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // bank from bit 16 and word from bits 15..2, higher bits alias
    function automatic int key_of(input addr_t a);
        return int'({a[16], a[15:2]});
    endfunction

    function automatic addr_t make_addr(input bank_sel_t bank, input word_addr_t word,
                                        input logic [14:0] upper);
        return {upper, bank, word, 2'($urandom)};
    endfunction

    function automatic void model_write(input addr_t a, input strb_t s, input data_t d);
        data_t w;
        int    k;
        k = key_of(a);
        w = model.exists(k) ? model[k] : '0;
        for (int i = 0; i < STRB_W; i++) begin
            if (s[i]) begin
                w[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        model[k] = w;
    endfunction

    function automatic data_t model_read(input addr_t a);
        int k;
        k = key_of(a);
        if (!model.exists(k)) begin
            errors = errors + 1;
            $display("read of address %h that the bench never wrote", a);
            return '0;
        end
        return model[k];
    endfunction

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // one request cycle driven just after the edge
    task automatic drive(input logic c, input logic w, input addr_t a, input strb_t s,
                         input data_t d);
        @(posedge clk);
        #1;
        cs    = c;
        we    = w;
        addr  = a;
        strb  = s;
        wdata = d;
    endtask

    task automatic idle();
        drive(1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic write_word(input addr_t a, input strb_t s, input data_t d);
        drive(1'b1, 1'b1, a, s, d);
        model_write(a, s, d);
    endtask

    // result is sampled just before the edge after the request edge
    task automatic read_check(input addr_t a);
        data_t exp;
        exp = model_read(a);
        drive(1'b1, 1'b0, a, '0, '0);
        idle();
        #8;
        check_data("rdata", rdata, exp);
        last_rd = exp;
    endtask

    task automatic test_reset_and_first_read();
        addr_t a;
        #8;
        check_data("rdata after reset", rdata, '0);
        a = make_addr(1'b0, word_addr_t'($urandom), '0);
        write_word(a, 4'hf, data_t'($urandom));
        read_check(a);
        // reset again while a read result is showing
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        #8;
        check_data("rdata after reset", rdata, '0);
        // memory contents survive reset
        read_check(a);
    endtask

    task automatic test_full_words();
        word_addr_t w;
        addr_t      a0;
        addr_t      a1;
        for (int i = 0; i < 64; i++) begin
            w  = word_addr_t'($urandom);
            a0 = make_addr(1'b0, w, '0);
            a1 = make_addr(1'b1, w, '0);
            write_word(a0, 4'hf, data_t'($urandom));
            write_word(a1, 4'hf, data_t'($urandom));
            read_check(a0);
            read_check(a1);
        end
    endtask

    task automatic test_byte_strobes();
        addr_t a;
        for (int p = 0; p < 64; p++) begin
            a = make_addr(bank_sel_t'(p % 2), word_addr_t'($urandom), '0);
            write_word(a, 4'hf, data_t'($urandom));
            write_word(a, strb_t'(p % 16), data_t'($urandom));
            read_check(a);
        end
    endtask

    task automatic test_aliasing();
        word_addr_t w;
        addr_t      a;
        addr_t      twin;
        for (int i = 0; i < 32; i++) begin
            w    = word_addr_t'($urandom);
            a    = make_addr(bank_sel_t'(i % 2), w, '0);
            twin = make_addr(bank_sel_t'(i % 2), w, 15'($urandom) | 15'd1);
            write_word(a, 4'hf, data_t'($urandom));
            read_check(twin);
            write_word(twin, 4'hf, data_t'($urandom));
            read_check(a);
        end
    endtask

    // one read in flight while the next is accepted
    task automatic test_back_to_back();
        addr_t a [64];
        data_t exp [64];
        for (int i = 0; i < 64; i++) begin
            a[i] = make_addr(bank_sel_t'(i % 2), word_addr_t'($urandom), '0);
            write_word(a[i], 4'hf, data_t'($urandom));
        end
        for (int i = 0; i < 64; i++) begin
            exp[i] = model_read(a[i]);
        end
        drive(1'b1, 1'b0, a[0], '0, '0);
        for (int i = 1; i < 64; i++) begin
            drive(1'b1, 1'b0, a[i], '0, '0);
            #8;
            check_data("rdata", rdata, exp[i-1]);
        end
        idle();
        #8;
        check_data("rdata", rdata, exp[63]);
        last_rd = exp[63];
    endtask

    task automatic test_hold();
        word_addr_t w0;
        addr_t      a0;
        addr_t      a1;
        addr_t      a2;
        for (int i = 0; i < 8; i++) begin
            w0 = word_addr_t'($urandom);
            a0 = make_addr(1'b0, w0, '0);
            a1 = make_addr(1'b1, word_addr_t'($urandom), '0);
            a2 = make_addr(1'b0, word_addr_t'(w0 + 1), '0);
            write_word(a0, 4'hf, data_t'($urandom));
            write_word(a1, 4'hf, data_t'($urandom));
            read_check(a0);
            repeat (3) begin
                idle();
                #8;
                check_data("rdata held", rdata, last_rd);
            end
            write_word(a1, 4'hf, data_t'($urandom));
            idle();
            #8;
            check_data("rdata held", rdata, last_rd);
            // another word in the bank just read
            write_word(a2, 4'hf, data_t'($urandom));
            idle();
            #8;
            check_data("rdata held", rdata, last_rd);
            // overwrite the word just read
            write_word(a0, 4'h5, data_t'($urandom));
            idle();
            #8;
            check_data("rdata held", rdata, last_rd);
            read_check(a0);
        end
    endtask

    initial begin
        reset   = 1'b1;
        cs      = 1'b0;
        we      = 1'b0;
        addr    = '0;
        strb    = '0;
        wdata   = '0;
        errors  = 0;
        checks  = 0;
        last_rd = '0;
        void'($urandom(SEED));
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_and_first_read();
        test_full_words();
        test_byte_strobes();
        test_aliasing();
        test_back_to_back();
        test_hold();
        idle();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== common/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // data path
    localparam int DATA_W    = 32;
    localparam int STRB_W    = DATA_W / 8;

    // request address
    localparam int ADDR_W    = 32;
    localparam int BYTE_OFS  = 2;

    // word index inside one bank
    localparam int WORD_AW   = 14;
    localparam int BANK_WORDS = 2 ** WORD_AW;

    // bank field sits right above the word index
    localparam int NUM_BANKS = 2;
    localparam int BANK_AW   = 1;
    localparam int BANK_LSB  = BYTE_OFS + WORD_AW;

    // one data word
    typedef logic [DATA_W-1:0]    data_t;

    // byte lane enables, bit i covers byte lane i
    typedef logic [STRB_W-1:0]    strb_t;

    // byte address as presented by the requester
    typedef logic [ADDR_W-1:0]    addr_t;

    // word index within a bank
    typedef logic [WORD_AW-1:0]   word_addr_t;

    // bank number
    typedef logic [BANK_AW-1:0]   bank_sel_t;

    // one-hot bank select
    typedef logic [NUM_BANKS-1:0] bank_mask_t;

endpackage

`default_nettype wire

// ==== mem/bank_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_decode (
    input  logic                 cs,
    input  logic                 we,
    input  mem_pkg::addr_t       addr,

    output mem_pkg::bank_mask_t  bank_cs,
    output mem_pkg::word_addr_t  word_addr,
    output logic                 read_req,
    output mem_pkg::bank_sel_t   read_bank
);

    import mem_pkg::*;

    // bank number of the current request
    bank_sel_t bank_idx;

    // bank field, everything above it aliases
    assign bank_idx  = addr[BANK_LSB +: BANK_AW];

    // word index, byte offset bits are dropped
    assign word_addr = addr[BYTE_OFS +: WORD_AW];

    // one-hot select
    // no bank is touched on idle cycles
    always_comb begin
        bank_cs = '0;
        if (cs) begin
            bank_cs[bank_idx] = 1'b1;
        end
    end

    // reads are tagged with their bank so the
    // return stage knows where to pick the data
    assign read_req  = cs & ~we;
    assign read_bank = bank_idx;

endmodule

`default_nettype wire

// ==== mem/banked_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module banked_mem (
    input  logic                 clk,
    input  logic                 reset,

    // request strobe port
    input  logic                 cs,
    input  logic                 we,
    input  mem_pkg::addr_t       addr,
    input  mem_pkg::strb_t       strb,
    input  mem_pkg::data_t       wdata,

    // read data, one cycle after the read
    output mem_pkg::data_t       rdata
);

    import mem_pkg::*;

    bank_mask_t  bank_cs;
    word_addr_t  word_addr;
    logic        read_req;
    bank_sel_t   read_bank;
    data_t       bank_rdata [NUM_BANKS];

    // address split and bank select
    bank_decode u_bank_decode (
        .cs        ( cs        ),
        .we        ( we        ),
        .addr      ( addr      ),
        .bank_cs   ( bank_cs   ),
        .word_addr ( word_addr ),
        .read_req  ( read_req  ),
        .read_bank ( read_bank )
    );

    // sram banks
    // write data, strobes and we fan out to all of them
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        sram_bank u_sram_bank (
            .clk       ( clk           ),
            .reset     ( reset         ),
            .cs        ( bank_cs[i]    ),
            .we        ( we            ),
            .word_addr ( word_addr     ),
            .strb      ( strb          ),
            .wdata     ( wdata         ),
            .rdata     ( bank_rdata[i] )
        );
    end

    // pick the bank that served the last read
    read_return u_read_return (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .read_req   ( read_req   ),
        .read_bank  ( read_bank  ),
        .bank_rdata ( bank_rdata ),
        .rdata      ( rdata      )
    );

endmodule

`default_nettype wire

// ==== mem/read_return.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_return (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 read_req,
    input  mem_pkg::bank_sel_t   read_bank,
    input  mem_pkg::data_t       bank_rdata [mem_pkg::NUM_BANKS],

    output mem_pkg::data_t       rdata
);

    import mem_pkg::*;

    // bank of the most recent read
    bank_sel_t sel_q;

    // captured at the same edge the bank loads its output
    // writes and idle cycles leave it alone
    always_ff @(posedge clk) begin
        if (reset) begin
            sel_q <= '0;
        end
        else if (read_req) begin
            sel_q <= read_bank;
        end
    end

    // return mux
    // bank output registers only change on reads, so
    // rdata stays put across writes to either bank
    assign rdata = bank_rdata[sel_q];

endmodule

`default_nettype wire

// ==== mem/sram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cs,
    input  logic                 we,
    input  mem_pkg::word_addr_t  word_addr,
    input  mem_pkg::strb_t       strb,
    input  mem_pkg::data_t       wdata,

    output mem_pkg::data_t       rdata
);

    import mem_pkg::*;

    // storage array
    data_t mem [BANK_WORDS];

    // qualified strobes
    // chip select works as the clock enable of the bank
    logic  wr_en;
    logic  rd_en;

    assign wr_en = cs &  we;
    assign rd_en = cs & ~we;

    // byte-lane write
    // lanes with a clear strobe keep their old byte
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (strb[i]) begin
                    mem[word_addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // registered read port
    // holds its value until the next read of this bank
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end
        else if (rd_en) begin
            rdata <= mem[word_addr];
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds the banked memory testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module banked_mem_tb -f verilog.f -o banked_mem_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/banked_mem_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// ==== verilog.f ====
common/mem_pkg.sv
mem/bank_decode.sv
mem/sram_bank.sv
mem/read_return.sv
mem/banked_mem.sv
bench/clk_gen.sv
bench/banked_mem_tb.sv
